// ==== vlog.f ====
hw/bch_pkg.sv
hw/bch_encoder.sv
hw/error_injector.sv
hw/bch_decoder.sv
hw/bch_channel_top.sv
verif/bch_channel_assert.sv
verif/bch_channel_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the channel testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module bch_channel_tb -Mdir obj_dir || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/Vbch_channel_tb)"
echo "$sim_out"

grep -q "TESTBENCH PASSED" <<< "$sim_out" && echo "run ok" && exit 0 \
    || { echo "run failed"; exit 1; }

// ==== verif/bch_channel_tb.sv ====
`timescale 1ns/1ps

module bch_channel_tb;
    import bch_pkg::*;

    localparam int          CLK_HALF   = 4;   // 8 ns period
    localparam int          RST_CYCLES = 16;
    localparam logic [31:0] SEED       = 32'h6e47_bc58;

    logic       clk;
    logic       rst;
    logic       in_valid;
    data_t      in_data;
    logic       in_bch_en;
    err_count_t in_err_count;
    logic       in_credit;
    logic       out_valid;
    data_t      out_data;
    logic       out_bch_en;
    err_count_t out_corr_total;
    logic       out_credit;

    // stimulus table as one queue per column
    data_t      tbl_data[$];
    logic       tbl_bch_en[$];
    err_count_t tbl_err[$];
    int         tbl_delay[$];   // cycles before the consumer hands the credit back

    int exp_idx_q[$];   // table rows in flight in send order
    int ret_due_q[$];   // cycle at which each output credit goes back

    int cycle = 0;
    int cycle_limit;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int sent = 0;
    int received = 0;
    int credit_returns = 0;

    bch_channel_top dut (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_bch_en      (in_bch_en),
        .in_err_count   (in_err_count),
        .in_credit      (in_credit),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_bch_en     (out_bch_en),
        .out_corr_total (out_corr_total),
        .out_credit     (out_credit)
    );

    bind bch_channel_top bch_channel_assert u_assert (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_credit (out_credit)
    );

    //------------------------------------------------------------
    // table and expected values
    //------------------------------------------------------------
    task automatic add_entry(input data_t d, input logic en, input err_count_t e, input int dly);
        tbl_data.push_back(d);
        tbl_bch_en.push_back(en);
        tbl_err.push_back(e);
        tbl_delay.push_back(dly);
    endtask

    task automatic build_table();
        add_entry(8'h00, 1'b1, 4'd0,  1);   // coded and clean
        add_entry(8'ha5, 1'b1, 4'd0,  2);
        add_entry(8'h3c, 1'b1, 4'd1,  1);
        add_entry(8'hff, 1'b1, 4'd1,  6);
        add_entry(8'h5a, 1'b1, 4'd2,  3);
        add_entry(8'h81, 1'b1, 4'd2, 12);
        add_entry(8'h7e, 1'b1, 4'd3, 60);   // long holds drain the output credits
        add_entry(8'hc3, 1'b1, 4'd3, 50);
        add_entry(8'h96, 1'b0, 4'd0,  2);   // raw byte from here
        add_entry(8'h12, 1'b0, 4'd1,  1);
        add_entry(8'h34, 1'b0, 4'd3,  4);
        add_entry(8'hf0, 1'b0, 4'd8,  2);
        add_entry(8'h0f, 1'b0, 4'd12, 1);   // capped at eight flips
        add_entry(8'he7, 1'b1, 4'd3, 20);
        add_entry(8'h69, 1'b0, 4'd5,  3);
        add_entry(8'hb4, 1'b1, 4'd2,  1);
    endtask

    // coded frames get every flip corrected and a raw byte keeps at most eight
    function automatic err_count_t flips_expected(logic en, err_count_t e);
        if (!en && e > err_count_t'(RAW_BITS)) begin
            return err_count_t'(RAW_BITS);
        end
        return e;
    endfunction

    //------------------------------------------------------------
    // compare tasks
    //------------------------------------------------------------
    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input err_count_t got, input err_count_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // drive one frame for a single cycle
    task automatic send_frame(input int idx);
        in_valid     <= 1'b1;
        in_data      <= tbl_data[idx];
        in_bch_en    <= tbl_bch_en[idx];
        in_err_count <= tbl_err[idx];
        exp_idx_q.push_back(idx);
        sent++;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d frames came back",
                     cycle, received, tbl_data.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (!rst && in_credit) begin
            credit_returns <= credit_returns + 1;
        end
    end

    //------------------------------------------------------------
    // consumer and scoreboard
    //------------------------------------------------------------
    always @(posedge clk) begin : consumer
        int         idx;
        int         err_before;
        data_t      exp_data;
        logic       exp_en;
        err_count_t exp_cnt;
        out_credit <= 1'b0;
        if (ret_due_q.size() > 0 && ret_due_q[0] <= cycle) begin
            out_credit <= 1'b1;   // one credit back per cycle
            void'(ret_due_q.pop_front());
        end
        if (!rst && out_valid) begin
            received++;
            if (exp_idx_q.size() == 0) begin
                errors++;
                $display("a frame came out that was never sent, data %h", out_data);
            end else begin
                idx        = exp_idx_q.pop_front();
                exp_data   = tbl_data[idx];
                exp_en     = tbl_bch_en[idx];
                exp_cnt    = flips_expected(exp_en, tbl_err[idx]);
                err_before = errors;
                check_flag("out_bch_en", out_bch_en, exp_en);
                if (exp_en) begin
                    check_data("out_data", out_data, exp_data);
                    check_count("out_corr_total", out_corr_total, exp_cnt);
                end else begin
                    check_count("out_data flip count",
                                err_count_t'($countones(out_data ^ exp_data)), exp_cnt);
                    check_count("out_corr_total", out_corr_total, err_count_t'(0));
                end
                tests_run++;
                if (errors != err_before) begin
                    tests_failed++;
                end
                $display("test %0d: bch_en %0d err %0d data %h -> %h corr %0d %s",
                         idx, exp_en, tbl_err[idx], exp_data, out_data, out_corr_total,
                         (errors == err_before) ? "ok" : "mismatch");
                ret_due_q.push_back(cycle + tbl_delay[idx]);
            end
        end
    end

    //------------------------------------------------------------
    // reset, producer and end of run
    //------------------------------------------------------------
    initial begin
        int gap;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        in_bch_en    = 1'b0;
        in_err_count = '0;
        out_credit   = 1'b0;
        void'($urandom(SEED));
        build_table();
        cycle_limit = tbl_data.size() * 64 + 200;

        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < tbl_data.size(); i++) begin
            gap = $urandom_range(3, 0);   // idle cycles between frames
            repeat (gap) @(posedge clk);
            @(posedge clk);
            while (IN_CREDITS + credit_returns - sent <= 0) begin
                @(posedge clk);
            end
            send_frame(i);
        end

        wait (received >= tbl_data.size());
        repeat (4) @(posedge clk);

        if (credit_returns != sent) begin
            errors++;
            $display("producer got back %0d input credits for %0d frames sent",
                     credit_returns, sent);
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/bch_channel_assert.sv ====
`timescale 1ns/1ps

module bch_channel_assert (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic in_credit,
    input logic out_valid,
    input logic out_credit
);
    import bch_pkg::*;

    int out_held;   // credits the DUT may still spend
    int in_held;    // credits the producer holds

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_held <= OUT_CREDITS;
            in_held  <= IN_CREDITS;
        end else begin
            out_held <= out_held - int'(out_valid) + int'(out_credit);
            in_held  <= in_held - int'(in_valid) + int'(in_credit);
        end
    end

    //------------------------------------------------------------
    // output side
    //------------------------------------------------------------
    a_out_spend: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_held > 0)
        else $error("out_valid while no output credit is held");

    a_out_bound: assert property (@(posedge clk) disable iff (rst)
        out_held <= OUT_CREDITS)
        else $error("more output credits returned than were spent");

    //------------------------------------------------------------
    // input side
    //------------------------------------------------------------
    a_in_spend: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> in_held > 0)
        else $error("in_valid sent without an input credit");

    a_in_pulse: assert property (@(posedge clk) disable iff (rst)
        in_credit |=> !in_credit)
        else $error("in_credit held for more than one cycle");

    // quiet in and right after reset
    a_rst_quiet: assert property (@(posedge clk)
        rst |-> !out_valid && !in_credit)
        else $error("out_valid or in_credit high during reset");

    a_rst_exit: assert property (@(posedge clk)
        $fell(rst) |-> !out_valid && !in_credit)
        else $error("out_valid or in_credit high just after reset");

endmodule

// ==== hw/bch_channel_top.sv ====
`timescale 1ns/1ps

module bch_channel_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  bch_pkg::data_t      in_data,
    input  logic                in_bch_en,
    input  bch_pkg::err_count_t in_err_count,
    output logic                in_credit,
    output logic                out_valid,
    output bch_pkg::data_t      out_data,
    output logic                out_bch_en,
    output bch_pkg::err_count_t out_corr_total,
    input  logic                out_credit
);
    import bch_pkg::*;

    // encoder stage
    nibble_t     in_hi;
    nibble_t     in_lo;
    logic        enc_start;
    logic        enc_ack;
    logic        enc_hi_busy;
    logic        enc_lo_busy;
    logic        enc_hi_done;
    logic        enc_lo_done;
    logic        enc_busy;
    logic        enc_done;
    codeword_t   cw_hi;
    codeword_t   cw_lo;
    data_t       enc_raw;
    logic        enc_bch_en;
    err_count_t  enc_err;

    // injector stage
    logic        inj_start;
    logic        inj_ack;
    logic        inj_busy;
    logic        inj_done;
    frame_bits_t inj_frame_in;
    frame_bits_t inj_frame_out;
    logic        inj_bch_en;

    // decoder stage
    logic        dec_start;
    logic        dec_ack;
    logic        dec_hi_busy;
    logic        dec_lo_busy;
    logic        dec_hi_done;
    logic        dec_lo_done;
    logic        dec_busy;
    logic        dec_done;
    msg_t        dec_hi_msg;
    msg_t        dec_lo_msg;
    corr_count_t corr_hi;
    corr_count_t corr_lo;
    nibble_t     dec_hi_nib;
    nibble_t     dec_lo_nib;
    logic        dec_bch_en;
    data_t       dec_raw;

    // output side
    out_credit_t out_cnt;
    logic        out_go;

    //------------------------------------------------------------
    // stage handoffs, each ack rides on the next stage's start
    //------------------------------------------------------------
    assign in_hi     = in_data[7:4];
    assign in_lo     = in_data[3:0];
    assign enc_busy  = enc_hi_busy | enc_lo_busy;
    assign enc_done  = enc_hi_done & enc_lo_done;
    assign enc_start = in_valid && !enc_busy;

    assign inj_start = enc_done && !inj_busy;
    assign enc_ack   = inj_start;
    assign inj_frame_in = enc_bch_en ? {cw_hi, cw_lo} : frame_bits_t'(enc_raw);   // raw byte in 7..0

    assign dec_busy  = dec_hi_busy | dec_lo_busy;
    assign dec_done  = dec_hi_done & dec_lo_done;
    assign dec_start = inj_done && !dec_busy;
    assign inj_ack   = dec_start;

    assign out_go    = dec_done && (out_cnt != '0);
    assign dec_ack   = out_go;

    assign dec_hi_nib = dec_hi_msg[3:0];
    assign dec_lo_nib = dec_lo_msg[3:0];

    bch_encoder u_enc_hi (
        .clk      (clk),
        .rst      (rst),
        .start    (enc_start),
        .msg      (msg_t'(in_hi)),
        .busy     (enc_hi_busy),
        .done     (enc_hi_done),
        .ack      (enc_ack),
        .codeword (cw_hi)
    );

    bch_encoder u_enc_lo (
        .clk      (clk),
        .rst      (rst),
        .start    (enc_start),
        .msg      (msg_t'(in_lo)),
        .busy     (enc_lo_busy),
        .done     (enc_lo_done),
        .ack      (enc_ack),
        .codeword (cw_lo)
    );

    error_injector u_inj (
        .clk       (clk),
        .rst       (rst),
        .start     (inj_start),
        .frame_in  (inj_frame_in),
        .bch_en    (enc_bch_en),
        .err_count (enc_err),
        .busy      (inj_busy),
        .done      (inj_done),
        .ack       (inj_ack),
        .frame_out (inj_frame_out)
    );

    bch_decoder u_dec_hi (
        .clk        (clk),
        .rst        (rst),
        .start      (dec_start),
        .bypass     (!inj_bch_en),
        .received   (inj_frame_out[FRAME_BITS-1:BCH_N]),
        .busy       (dec_hi_busy),
        .done       (dec_hi_done),
        .ack        (dec_ack),
        .msg        (dec_hi_msg),
        .corr_count (corr_hi)
    );

    bch_decoder u_dec_lo (
        .clk        (clk),
        .rst        (rst),
        .start      (dec_start),
        .bypass     (!inj_bch_en),
        .received   (inj_frame_out[BCH_N-1:0]),
        .busy       (dec_lo_busy),
        .done       (dec_lo_done),
        .ack        (dec_ack),
        .msg        (dec_lo_msg),
        .corr_count (corr_lo)
    );

    //------------------------------------------------------------
    // credits
    //------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_credit <= 1'b0;
            out_valid <= 1'b0;
            out_cnt   <= out_credit_t'(OUT_CREDITS);
        end else begin
            in_credit <= inj_start;   // encoder slot frees next cycle
            out_valid <= out_go;
            case ({out_go, out_credit})
                2'b10:   out_cnt <= out_cnt - 1'b1;
                2'b01:   out_cnt <= out_cnt + 1'b1;
                default: out_cnt <= out_cnt;   // none, or spent and returned together
            endcase
        end
    end

    // per-frame fields follow their frame down the pipe
    always_ff @(posedge clk) begin
        if (enc_start) begin
            enc_raw    <= in_data;
            enc_bch_en <= in_bch_en;
            enc_err    <= in_err_count;
        end
        if (inj_start) begin
            inj_bch_en <= enc_bch_en;
        end
        if (dec_start) begin
            dec_bch_en <= inj_bch_en;
            dec_raw    <= inj_frame_out[RAW_BITS-1:0];
        end
        if (out_go) begin
            out_bch_en     <= dec_bch_en;
            out_data       <= dec_bch_en ? {dec_hi_nib, dec_lo_nib} : dec_raw;
            out_corr_total <= err_count_t'(corr_hi) + err_count_t'(corr_lo);   // 0 in bypass
        end
    end

endmodule

// ==== hw/bch_decoder.sv ====
`timescale 1ns/1ps

module bch_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 bypass,
    input  bch_pkg::codeword_t   received,
    output logic                 busy,
    output logic                 done,
    input  logic                 ack,
    output bch_pkg::msg_t        msg,
    output bch_pkg::corr_count_t corr_count
);
    import bch_pkg::*;

    dec_state_t state;
    msg_t       cand;        // next candidate message
    codeword_t  rx_r;
    msg_t       best_msg;
    dist_t      best_dist;
    codeword_t  rx_cur;
    msg_t       cand_cur;
    dist_t      dist_cur;
    logic       take;

    assign take = (state == DEC_IDLE) && start;

    // candidate 0 is scored on the start cycle from the port
    assign rx_cur   = (state == DEC_IDLE) ? received : rx_r;
    assign cand_cur = (state == DEC_IDLE) ? msg_t'(0) : cand;
    assign dist_cur = dist_t'($countones(bch_encode(cand_cur) ^ rx_cur));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= DEC_IDLE;
            cand  <= '0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (start) begin
                        state <= bypass ? DEC_HOLD : DEC_SEARCH;
                        cand  <= msg_t'(1);
                    end
                end
                DEC_SEARCH: begin
                    cand <= cand + msg_t'(1);
                    if (cand == '1) begin
                        state <= DEC_HOLD;   // all 32 seen
                    end
                end
                DEC_HOLD: begin
                    if (ack) begin
                        state <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    // best so far, strict compare keeps the first of a tie
    always_ff @(posedge clk) begin
        if (take) begin
            rx_r      <= received;
            best_msg  <= '0;
            best_dist <= bypass ? dist_t'(0) : dist_cur;
        end else if (state == DEC_SEARCH && dist_cur < best_dist) begin
            best_msg  <= cand;
            best_dist <= dist_cur;
        end
    end

    assign busy       = (state != DEC_IDLE);
    assign done       = (state == DEC_HOLD);
    assign msg        = best_msg;
    assign corr_count = (best_dist > dist_t'(7)) ? corr_count_t'(7) : best_dist[2:0];

endmodule

// ==== hw/error_injector.sv ====
`timescale 1ns/1ps

module error_injector (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  bch_pkg::frame_bits_t frame_in,
    input  logic                 bch_en,
    input  bch_pkg::err_count_t  err_count,
    output logic                 busy,
    output logic                 done,
    input  logic                 ack,
    output bch_pkg::frame_bits_t frame_out
);
    import bch_pkg::*;

    inj_state_t  state;
    logic [15:0] lfsr;
    frame_bits_t frame_r;
    frame_bits_t used;        // positions already flipped
    frame_bits_t flip_mask;
    logic [31:0] used_ext;
    logic        bch_en_r;
    err_count_t  err_r;
    err_count_t  flip_cnt;
    err_count_t  target;
    logic [4:0]  idx;
    logic        in_range;
    logic        accept;

    //------------------------------------------------------------
    // index draw and acceptance
    //------------------------------------------------------------
    assign idx       = lfsr[4:0];
    assign used_ext  = {2'b11, used};   // 30 and 31 never valid
    assign in_range  = bch_en_r ? (idx < 5'(FRAME_BITS)) : (idx < 5'(RAW_BITS));
    assign accept    = in_range && !used_ext[idx];
    assign flip_mask = frame_bits_t'(32'd1 << idx);

    // raw byte has only eight bits to hit
    assign target = (!bch_en_r && err_r > err_count_t'(RAW_BITS)) ?
                    err_count_t'(RAW_BITS) : err_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= INJ_IDLE;
            lfsr     <= LFSR_SEED;
            flip_cnt <= '0;
        end else begin
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? LFSR_TAPS : 16'h0000);   // free running
            case (state)
                INJ_IDLE: begin
                    if (start) begin
                        state <= INJ_LOAD;
                    end
                end
                INJ_LOAD: begin
                    flip_cnt <= '0;
                    state    <= (target == '0) ? INJ_HOLD : INJ_FLIP;
                end
                INJ_FLIP: begin
                    if (accept) begin
                        flip_cnt <= flip_cnt + 4'd1;
                        if (flip_cnt + 4'd1 == target) begin
                            state <= INJ_HOLD;
                        end
                    end
                end
                INJ_HOLD: begin
                    if (ack) begin
                        state <= INJ_IDLE;
                    end
                end
                default: state <= INJ_IDLE;
            endcase
        end
    end

    //------------------------------------------------------------
    // frame and mask
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == INJ_IDLE && start) begin
            frame_r  <= frame_in;
            bch_en_r <= bch_en;
            err_r    <= err_count;
        end
        if (state == INJ_LOAD) begin
            used <= '0;
        end else if (state == INJ_FLIP && accept) begin
            frame_r <= frame_r ^ flip_mask;
            used    <= used | flip_mask;
        end
    end

    assign busy      = (state != INJ_IDLE);
    assign done      = (state == INJ_HOLD);
    assign frame_out = frame_r;

endmodule

// ==== hw/bch_encoder.sv ====
`timescale 1ns/1ps

module bch_encoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  bch_pkg::msg_t      msg,
    output logic               busy,
    output logic               done,
    input  logic               ack,
    output bch_pkg::codeword_t codeword
);
    import bch_pkg::*;

    msg_t             msg_r;
    logic [BCH_R-1:0] rem;
    logic [2:0]       bit_cnt;   // index of the next message bit, from the top
    logic             running;
    logic             in_bit;
    logic             take;

    assign take = start && !busy;

    // first bit comes straight from the port on the start cycle
    assign in_bit = running ? msg_r[BCH_K - 1 - bit_cnt] : msg[BCH_K-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end else begin
            if (take) begin
                running <= 1'b1;
                bit_cnt <= 3'd1;
            end else if (running) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'(BCH_K - 1)) begin
                    running <= 1'b0;   // last bit shifted in this cycle
                    done    <= 1'b1;
                end
            end else if (done && ack) begin
                done <= 1'b0;
            end
        end
    end

    // remainder register
    always_ff @(posedge clk) begin
        if (take) begin
            msg_r <= msg;
            rem   <= bch_step('0, in_bit);
        end else if (running) begin
            rem <= bch_step(rem, in_bit);
        end
    end

    assign busy     = running | done;
    assign codeword = {msg_r, rem};   // message above parity

endmodule

// ==== hw/bch_pkg.sv ====
package bch_pkg;

    // ------------------------------------------------------------
    // code and frame sizes
    // ------------------------------------------------------------
    localparam int BCH_N      = 15;              // codeword length
    localparam int BCH_K      = 5;               // message length
    localparam int BCH_T      = 3;               // correctable bits
    localparam int BCH_R      = BCH_N - BCH_K;   // parity bits
    localparam int FRAME_BITS = 30;
    localparam int RAW_BITS   = 8;

    localparam logic [BCH_R:0] BCH_GEN = 11'b10100110111;

    // injector prng
    localparam logic [15:0] LFSR_SEED = 16'hace1;
    localparam logic [15:0] LFSR_TAPS = 16'hb400; // x^16+x^14+x^13+x^11+1

    // flow control
    localparam int IN_CREDITS  = 1;
    localparam int OUT_CREDITS = 2;

    typedef logic [7:0]            data_t;
    typedef logic [3:0]            nibble_t;
    typedef logic [BCH_K-1:0]      msg_t;
    typedef logic [BCH_N-1:0]      codeword_t;
    typedef logic [FRAME_BITS-1:0] frame_bits_t;
    typedef logic [3:0]            err_count_t;
    typedef logic [2:0]            corr_count_t;   // saturates at 7
    typedef logic [3:0]            dist_t;
    typedef logic [$clog2(OUT_CREDITS+1)-1:0] out_credit_t;

    typedef enum logic [1:0] {INJ_IDLE, INJ_LOAD, INJ_FLIP, INJ_HOLD} inj_state_t;
    typedef enum logic [1:0] {DEC_IDLE, DEC_SEARCH, DEC_HOLD} dec_state_t;

    // one step of the polynomial division, message bit msb first
    function automatic logic [BCH_R-1:0] bch_step(logic [BCH_R-1:0] rem, logic din);
        logic fb;
        fb = rem[BCH_R-1] ^ din;
        return {rem[BCH_R-2:0], 1'b0} ^ ({BCH_R{fb}} & BCH_GEN[BCH_R-1:0]);
    endfunction

    // whole systematic codeword in one go, used by the decoder search
    function automatic codeword_t bch_encode(msg_t m);
        logic [BCH_R-1:0] rem;
        rem = '0;
        for (int i = BCH_K - 1; i >= 0; i--) begin
            rem = bch_step(rem, m[i]);
        end
        return {m, rem};
    endfunction

endpackage
